/* sim.f */
+incdir+common
common/mm_pkg.sv
rtl/word_ram.sv
mm_core/mm_sequencer.sv
mm_core/mm_mac.sv
mm_core/mm_result_writer.sv
rtl/mm_top.sv
sim/mm_clk_gen.sv
sim/mm_props.sv
sim/mm_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mm_tb -f sim.f -o mm_sim

./obj_dir/mm_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

/* sim/mm_tb.sv */
`include "mm_defs.svh"

module mm_tb
    import mm_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        int   m;
        int   n;
        int   k;
        logic full;
        int   poke;
    } job_row_t;

    localparam int          SEED         = 32'heba7035d;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_ROWS     = 8;
    // Shape, operand range and the cycle of a stray start (0 for none)
    localparam job_row_t    ROWS [NUM_ROWS] = '{
        '{1, 1, 1, 1'b0, 0},
        '{2, 3, 4, 1'b0, 0},
        '{4, 4, 4, 1'b0, 0},
        '{7, 1, 5, 1'b0, 0},
        '{1, 8, 1, 1'b0, 0},
        '{4, 4, 4, 1'b1, 0},
        '{2, 3, 4, 1'b1, 0},
        '{4, 4, 4, 1'b0, 6}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  load_en;
    mm_ram_sel_t           load_sel;
    logic [`MM_ADDR_W-1:0] load_addr;
    logic [`MM_DATA_W-1:0] load_data;
    logic                  start;
    mm_dims_t              dims;
    logic [`MM_ADDR_W-1:0] rd_addr;
    logic [`MM_DATA_W-1:0] rd_data;
    logic                  busy;
    logic                  done;

    // Host-side copies of the memories and the expected C
    logic [`MM_DATA_W-1:0] a_words [`MM_RAM_DEPTH];
    logic [`MM_DATA_W-1:0] b_words [`MM_RAM_DEPTH];
    logic [`MM_DATA_W-1:0] exp_c   [`MM_RAM_DEPTH];

    int err_cnt;
    int check_cnt;
    int cycle_cnt;
    int cycle_limit;

    mm_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mm_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .dims      (dims),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    // Job itself, loads, readback and some slack
    function automatic int job_budget(int m, int n, int k);
        return m * n * k + m * n + m * k + k * n + 50;
    endfunction

    function automatic int total_budget();
        int sum;
        sum = RESET_CYCLES + 50;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += job_budget(ROWS[r].m, ROWS[r].n, ROWS[r].k);
        end
        // Back-to-back pair
        sum += job_budget(4, 4, 4) + job_budget(2, 3, 4);
        return sum;
    endfunction

    function automatic mm_dims_t make_dims(int m, int n, int k);
        mm_dims_t d;
        d.m = `MM_DIM_W'(m);
        d.n = `MM_DIM_W'(n);
        d.k = `MM_DIM_W'(k);
        return d;
    endfunction

    function automatic logic [`MM_DATA_W-1:0] rand_word(logic full);
        if (full) begin
            return $urandom;
        end
        // Small range is -8 to 7
        return 32'($urandom_range(15, 0)) - 32'd8;
    endfunction

    // Exact signed dot products, low 32 bits kept
    function automatic void compute_expected(int m, int n, int k);
        longint sum;
        for (int i = 0; i < m; i++) begin
            for (int j = 0; j < n; j++) begin
                sum = 0;
                for (int p = 0; p < k; p++) begin
                    sum += longint'($signed(a_words[i * k + p])) *
                           longint'($signed(b_words[p * n + j]));
                end
                exp_c[i * n + j] = sum[31:0];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic load_word(input mm_ram_sel_t sel, input int addr,
                             input logic [`MM_DATA_W-1:0] data);
        load_en   = 1'b1;
        load_sel  = sel;
        load_addr = `MM_ADDR_W'(addr);
        load_data = data;
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic load_operands(input int m, input int n, input int k, input logic full);
        for (int idx = 0; idx < m * k; idx++) begin
            a_words[idx] = rand_word(full);
            load_word(SEL_A, idx, a_words[idx]);
        end
        for (int idx = 0; idx < k * n; idx++) begin
            b_words[idx] = rand_word(full);
            load_word(SEL_B, idx, b_words[idx]);
        end
    endtask

    // Starts a job and follows busy and done cycle by cycle
    task automatic run_job(input string name, input int m, input int n, input int k,
                           input int poke);
        int cycles;
        int total;
        total = m * n * k;
        dims  = make_dims(m, n, k);
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 1;
        while (!done) begin
            check_value({name, " busy"}, 1, busy);
            // Stray start while busy must be ignored
            if (cycles == poke) begin
                dims  = make_dims(1, 1, 1);
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        start = 1'b0;
        check_value({name, " busy at done"}, 1, busy);
        check_value({name, " latency"}, total + 3, cycles);
        @(posedge clk);
        #1;
        check_value({name, " busy after done"}, 0, busy);
        check_value({name, " done width"}, 0, done);
    endtask

    task automatic read_results(input string name, input int count);
        for (int idx = 0; idx < count; idx++) begin
            rd_addr = `MM_ADDR_W'(idx);
            @(posedge clk);
            #1;
            check_value($sformatf("%s C[%0d]", name, idx), exp_c[idx], rd_data);
        end
    endtask

    task automatic check_zero_start();
        dims  = make_dims(2, 2, 0);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (8) begin
            check_value("zero_k busy", 0, busy);
            check_value("zero_k done", 0, done);
            @(posedge clk);
            #1;
        end
        // Earlier results stay in place
        read_results("zero_k", 16);
    endtask

    task automatic back_to_back();
        load_operands(4, 4, 4, 1'b1);
        compute_expected(4, 4, 4);
        run_job("b2b_first", 4, 4, 4, 0);
        // Second job overwrites C[0..5] only
        compute_expected(2, 3, 4);
        run_job("b2b_second", 2, 3, 4, 0);
        read_results("b2b", 16);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        string name;
        int    seed_dummy;
        load_en     = 1'b0;
        load_sel    = SEL_A;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        dims        = '0;
        rd_addr     = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        cycle_cnt   = 0;
        seed_dummy  = $urandom(SEED);
        cycle_limit = total_budget();

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);

        for (int r = 0; r < NUM_ROWS; r++) begin
            name = $sformatf("%0dx%0dx%0d_%s%s", ROWS[r].m, ROWS[r].n, ROWS[r].k,
                             ROWS[r].full ? "full" : "small",
                             (ROWS[r].poke != 0) ? "_poke" : "");
            load_operands(ROWS[r].m, ROWS[r].n, ROWS[r].k, ROWS[r].full);
            compute_expected(ROWS[r].m, ROWS[r].n, ROWS[r].k);
            run_job(name, ROWS[r].m, ROWS[r].n, ROWS[r].k, ROWS[r].poke);
            read_results(name, ROWS[r].m * ROWS[r].n);
        end

        check_zero_start();
        back_to_back();

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim/mm_props.sv */
module mm_props (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    // A done pulse lasts one cycle
    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // Busy drops only right after the done pulse
    busy_fall_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(done))
        else $error("busy fell without a preceding done pulse");

    // Busy only rises from an accepted start
    busy_rise_on_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else $error("busy rose without start");

endmodule

bind mm_top mm_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

/* sim/mm_clk_gen.sv */
module mm_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* rtl/mm_top.sv */
`include "mm_defs.svh"

module mm_top
    import mm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_en,
    input  mm_ram_sel_t           load_sel,
    input  logic [`MM_ADDR_W-1:0] load_addr,
    input  logic [`MM_DATA_W-1:0] load_data,
    input  logic                  start,
    input  mm_dims_t              dims,
    input  logic [`MM_ADDR_W-1:0] rd_addr,
    output logic [`MM_DATA_W-1:0] rd_data,
    output logic                  busy,
    output logic                  done
);

    mm_issue_t  issue;
    mm_result_t result;

    logic [`MM_DATA_W-1:0] a_data;
    logic [`MM_DATA_W-1:0] b_data;
    logic                  c_we;
    logic [`MM_ADDR_W-1:0] c_waddr;
    logic [`MM_DATA_W-1:0] c_wdata;

    // Operand memories, written by the host and read by the sequencer
    word_ram #(.DEPTH(`MM_RAM_DEPTH)) u_ram_a (
        .clk   (clk),
        .we    (load_en && (load_sel == SEL_A)),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (issue.a_addr),
        .rdata (a_data)
    );

    word_ram #(.DEPTH(`MM_RAM_DEPTH)) u_ram_b (
        .clk   (clk),
        .we    (load_en && (load_sel == SEL_B)),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (issue.b_addr),
        .rdata (b_data)
    );

    // Result memory, read port serves host readback
    word_ram #(.DEPTH(`MM_RAM_DEPTH)) u_ram_c (
        .clk   (clk),
        .we    (c_we),
        .waddr (c_waddr),
        .wdata (c_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    mm_sequencer u_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .dims  (dims),
        .done  (done),
        .issue (issue),
        .busy  (busy)
    );

    mm_mac u_mac (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .a_data (a_data),
        .b_data (b_data),
        .result (result)
    );

    mm_result_writer u_writer (
        .clk     (clk),
        .rst_n   (rst_n),
        .result  (result),
        .c_we    (c_we),
        .c_waddr (c_waddr),
        .c_wdata (c_wdata),
        .done    (done)
    );

endmodule

/* mm_core/mm_result_writer.sv */
`include "mm_defs.svh"

module mm_result_writer
    import mm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  mm_result_t            result,
    output logic                  c_we,
    output logic [`MM_ADDR_W-1:0] c_waddr,
    output logic [`MM_DATA_W-1:0] c_wdata,
    output logic                  done
);

    // Each valid result goes straight into the C memory at its own address
    assign c_we    = result.valid;
    assign c_waddr = result.c_addr;
    assign c_wdata = result.value;

    // Done follows the write of the final element by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= result.valid && result.final_elem;
        end
    end

endmodule

/* mm_core/mm_mac.sv */
`include "mm_defs.svh"

module mm_mac
    import mm_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  mm_issue_t                    issue,
    input  logic signed [`MM_DATA_W-1:0] a_data,
    input  logic signed [`MM_DATA_W-1:0] b_data,
    output mm_result_t                   result
);

    mm_issue_t tag_q;

    logic signed [`MM_ACC_W-1:0] product;
    logic signed [`MM_ACC_W-1:0] acc;
    logic signed [`MM_ACC_W-1:0] acc_next;

    // Tag waits one cycle for the registered memory read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= issue;
        end
    end

    // Full signed product, both operands sign extended
    assign product = a_data * b_data;

    // First product of a dot product seeds the sum directly
    assign acc_next = tag_q.first ? product : acc + product;

    always_ff @(posedge clk) begin
        if (tag_q.valid) begin
            acc <= acc_next;
        end
    end

    // Element leaves together with its last accumulation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid      <= tag_q.valid && tag_q.last;
            result.final_elem <= tag_q.valid && tag_q.last && tag_q.final_elem;
            result.c_addr     <= tag_q.c_addr;
            result.value      <= acc_next[`MM_DATA_W-1:0];
        end
    end

endmodule

/* mm_core/mm_sequencer.sv */
`include "mm_defs.svh"

module mm_sequencer
    import mm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  mm_dims_t  dims,
    input  logic      done,
    output mm_issue_t issue,
    output logic      busy
);

    localparam int ADDR_W = `MM_ADDR_W;

    mm_dims_t dims_q;
    logic     running;
    logic     start_ok;
    logic     p_end;
    logic     j_end;
    logic     i_end;

    logic [`MM_DIM_W-1:0] i_idx;
    logic [`MM_DIM_W-1:0] j_idx;
    logic [`MM_DIM_W-1:0] p_idx;

    // Running address bases, updated by adding only
    logic [ADDR_W-1:0] a_addr;
    logic [ADDR_W-1:0] b_addr;
    logic [ADDR_W-1:0] c_addr;
    logic [ADDR_W-1:0] a_row_base;
    logic [ADDR_W-1:0] n_ext;
    logic [ADDR_W-1:0] k_ext;

    assign start_ok = start && !busy &&
                      (dims.m != '0) && (dims.n != '0) && (dims.k != '0);

    assign p_end = (p_idx == dims_q.k - 1'b1);
    assign j_end = (j_idx == dims_q.n - 1'b1);
    assign i_end = (i_idx == dims_q.m - 1'b1);

    assign n_ext = ADDR_W'(dims_q.n);
    assign k_ext = ADDR_W'(dims_q.k);

    always_ff @(posedge clk) begin
        if (start_ok) begin
            dims_q <= dims;
        end
    end

    // Loop walk: p fastest, then j, then i
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            running    <= 1'b0;
            i_idx      <= '0;
            j_idx      <= '0;
            p_idx      <= '0;
            a_addr     <= '0;
            b_addr     <= '0;
            c_addr     <= '0;
            a_row_base <= '0;
        end else if (start_ok) begin
            busy       <= 1'b1;
            running    <= 1'b1;
            i_idx      <= '0;
            j_idx      <= '0;
            p_idx      <= '0;
            a_addr     <= '0;
            b_addr     <= '0;
            c_addr     <= '0;
            a_row_base <= '0;
        end else begin
            if (done) begin
                busy <= 1'b0;
            end
            if (running) begin
                if (!p_end) begin
                    p_idx  <= p_idx + 1'b1;
                    a_addr <= a_addr + 1'b1;
                    b_addr <= b_addr + n_ext;
                end else begin
                    p_idx  <= '0;
                    c_addr <= c_addr + 1'b1;
                    if (!j_end) begin
                        // Next column, same row of A
                        j_idx  <= j_idx + 1'b1;
                        a_addr <= a_row_base;
                        b_addr <= ADDR_W'(j_idx) + 1'b1;
                    end else begin
                        // Next row of A, back to column 0 of B
                        j_idx      <= '0;
                        i_idx      <= i_idx + 1'b1;
                        a_row_base <= a_row_base + k_ext;
                        a_addr     <= a_row_base + k_ext;
                        b_addr     <= '0;
                        if (i_end) begin
                            running <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        issue.a_addr     = a_addr;
        issue.b_addr     = b_addr;
        issue.c_addr     = c_addr;
        issue.first      = (p_idx == '0);
        issue.last       = p_end;
        issue.final_elem = p_end && j_end && i_end;
        issue.valid      = running;
    end

endmodule

/* rtl/word_ram.sv */
`include "mm_defs.svh"

module word_ram #(
    parameter int DEPTH = `MM_RAM_DEPTH
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`MM_ADDR_W-1:0] waddr,
    input  logic [`MM_DATA_W-1:0] wdata,
    input  logic [`MM_ADDR_W-1:0] raddr,
    output logic [`MM_DATA_W-1:0] rdata
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [`MM_DATA_W-1:0] mem [DEPTH];

    // Only the low address bits select a word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr[IDX_W-1:0]];
    end

endmodule

/* common/mm_pkg.sv */
`include "mm_defs.svh"

package mm_pkg;

    // Job dimensions, C is m x n and the inner dimension is k
    typedef struct packed {
        logic [`MM_DIM_W-1:0] m;
        logic [`MM_DIM_W-1:0] n;
        logic [`MM_DIM_W-1:0] k;
    } mm_dims_t;

    // Target of a host load
    typedef enum logic {
        SEL_A = 1'b0,
        SEL_B = 1'b1
    } mm_ram_sel_t;

    // One product request from the sequencer
    typedef struct packed {
        logic [`MM_ADDR_W-1:0] a_addr;
        logic [`MM_ADDR_W-1:0] b_addr;
        logic [`MM_ADDR_W-1:0] c_addr;
        logic                  first;
        logic                  last;
        logic                  final_elem;
        logic                  valid;
    } mm_issue_t;

    // Finished element on its way to the C memory
    typedef struct packed {
        logic [`MM_ADDR_W-1:0] c_addr;
        logic [`MM_DATA_W-1:0] value;
        logic                  final_elem;
        logic                  valid;
    } mm_result_t;

endpackage

/* common/mm_defs.svh */
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// Matrix dimension field width, covers up to 1023 rows or columns
`define MM_DIM_W 10

// Word memory address width
`define MM_ADDR_W 16

// Operand and result word width
`define MM_DATA_W 32

// Accumulator width, wide enough for a full 32x32 signed product
`define MM_ACC_W 64

// Words per memory
`define MM_RAM_DEPTH 256

`endif
